// ==== Bender.yml ====
package:
  name: tracker

sources:
  - files:
      - hw/tracker_pkg.sv
      - hw/baseline_calibrator.sv
      - hw/posture_feedback.sv
      - hw/stereo_compositor.sv
      - hw/tracker_top.sv

  - target: test
    files:
      - tb/pixel_memory_model.sv
      - tb/tb_tracker_top.sv

// ==== hw/baseline_calibrator.sv ====
//================================================
// Marker baseline calibration
//================================================

`default_nettype none

module baseline_calibrator (
	input  logic                     CLOCK_50,
	input  logic                     reset,
	input  logic                     run,
	input  tracker_pkg::marker_set_t marker_coords,
	output tracker_pkg::marker_set_t baseline,
	output logic                     done
);
	import tracker_pkg::*;

	// Wide enough to hold 128 full-scale samples
	localparam int ACC_W = $bits(coord_t) + CALIB_SAMPLES_LOG2;

	typedef logic [ACC_W-1:0] calib_acc_t;
	typedef logic [CALIB_SAMPLES_LOG2-1:0] sample_count_t;

	typedef enum logic [1:0] {
		CALIB_SAMPLE,
		CALIB_AVERAGE,
		CALIB_DONE
	} calib_state_t;

	calib_state_t  state;
	sample_count_t sample_count;
	logic          sampling;

	// One accumulator per marker and axis
	calib_acc_t acc_x [3];
	calib_acc_t acc_y [3];
	calib_acc_t acc_z [3];

	assign sampling = run && (state == CALIB_SAMPLE);
	assign done = (state == CALIB_DONE);

	//================================================
	// Control
	//================================================

	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			state <= CALIB_SAMPLE;
			sample_count <= '0;
		end else begin
			case (state)
				CALIB_SAMPLE: begin
					if (run) begin
						sample_count <= sample_count + 1'b1;
						// Last of the 128 samples
						if (sample_count == '1) begin
							state <= CALIB_AVERAGE;
						end
					end
				end
				CALIB_AVERAGE: begin
					state <= CALIB_DONE;
				end
				default: begin
					state <= CALIB_DONE;
				end
			endcase
		end
	end

	//================================================
	// Sums and floor mean
	//================================================

	always_ff @(posedge CLOCK_50) begin
		for (int m = 0; m < 3; m++) begin
			if (sampling) begin
				// First sample loads, the rest add
				if (sample_count == '0) begin
					acc_x[m] <= calib_acc_t'(marker_coords[m].x);
					acc_y[m] <= calib_acc_t'(marker_coords[m].y);
					acc_z[m] <= calib_acc_t'(marker_coords[m].z);
				end else begin
					acc_x[m] <= acc_x[m] + calib_acc_t'(marker_coords[m].x);
					acc_y[m] <= acc_y[m] + calib_acc_t'(marker_coords[m].y);
					acc_z[m] <= acc_z[m] + calib_acc_t'(marker_coords[m].z);
				end
			end
			// Divide by 128 by dropping the low bits
			if (state == CALIB_AVERAGE) begin
				baseline[m].x <= acc_x[m][CALIB_SAMPLES_LOG2 +: $bits(coord_t)];
				baseline[m].y <= acc_y[m][CALIB_SAMPLES_LOG2 +: $bits(coord_t)];
				baseline[m].z <= acc_z[m][CALIB_SAMPLES_LOG2 +: $bits(coord_t)];
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/posture_feedback.sv ====
//================================================
// Posture height feedback
//================================================

`default_nettype none

module posture_feedback (
	input  logic                        CLOCK_50,
	input  logic                        reset,
	input  logic                        run,
	input  logic                        calibrated,
	input  tracker_pkg::marker_set_t    marker_coords,
	input  tracker_pkg::marker_set_t    baseline,
	input  tracker_pkg::marker_sel_t    marker_sel,
	input  tracker_pkg::coord_t         threshold,
	output tracker_pkg::feedback_code_t feedback_code,
	output logic                        posture_wrong
);
	import tracker_pkg::*;

	marker_sel_t   sel_idx;
	marker_coord_t tracked;
	marker_coord_t tracked_base;
	deviation_t    deviation;
	deviation_t    thr_pos;
	deviation_t    thr_neg;
	logic          stage1_valid;

	// Marker 3 does not exist, fold it onto marker 2
	assign sel_idx = (marker_sel == 2'd3) ? 2'd2 : marker_sel;
	assign tracked = marker_coords[sel_idx];
	assign tracked_base = baseline[sel_idx];

	assign thr_pos = deviation_t'({2'b00, threshold});
	assign thr_neg = -thr_pos;

	//================================================
	// Stage 1, height deviation
	//================================================

	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			stage1_valid <= 1'b0;
		end else if (run) begin
			stage1_valid <= calibrated;
		end
	end

	always_ff @(posedge CLOCK_50) begin
		if (run) begin
			deviation <= deviation_t'({2'b00, tracked.y})
				- deviation_t'({2'b00, tracked_base.y});
		end
	end

	//================================================
	// Stage 2, classification
	//================================================

	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			feedback_code <= FB_CALIBRATING;
			posture_wrong <= 1'b0;
		end else if (run && stage1_valid) begin
			if (deviation > thr_pos) begin
				feedback_code <= FB_MOVE_LOWER;
				posture_wrong <= 1'b1;
			end else if (deviation < thr_neg) begin
				// Too low, flag keeps its last value
				feedback_code <= FB_MOVE_HIGHER;
			end else begin
				feedback_code <= FB_HOLD;
				posture_wrong <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/stereo_compositor.sv ====
//================================================
// Stereo frame compositor
//================================================

`default_nettype none

module stereo_compositor #(
	parameter int FRAME_WIDTH  = 320,
	parameter int FRAME_HEIGHT = 240,
	parameter int FB_STRIDE    = 1024
) (
	input  logic                      CLOCK_50,
	input  logic                      reset,
	input  logic                      run,
	input  tracker_pkg::view_mode_t   view_mode,
	output tracker_pkg::mem_req_t     mem_req,
	input  logic                      mem_ack,
	input  tracker_pkg::stereo_word_t mem_rdata,
	output tracker_pkg::fb_write_t    fb_wr
);
	import tracker_pkg::*;

	localparam int COL_W = $clog2(FRAME_WIDTH);
	localparam int ROW_W = $clog2(FRAME_HEIGHT);

	typedef logic [COL_W-1:0] col_t;
	typedef logic [ROW_W-1:0] row_t;

	typedef enum logic {
		SCAN_READ,
		SCAN_WRITE
	} scan_state_t;

	localparam col_t LAST_COL = col_t'(FRAME_WIDTH - 1);
	localparam row_t LAST_ROW = row_t'(FRAME_HEIGHT - 1);

	scan_state_t state;
	col_t        x;
	row_t        y;
	col_t        x_next;
	row_t        y_next;
	logic        rd_strobe;
	logic        wr_strobe;
	pixel_t      wr_data;
	logic        rd_done;

	// Stored byte order is blue, green, red from the top
	function automatic pixel_t to_rgb332(input logic [7:0] raw);
		return {raw[2:0], raw[5:3], raw[7:6]};
	endfunction

	function automatic pixel_t compose(input stereo_word_t word, input view_mode_t mode);
		pixel_t left;
		pixel_t right;
		left = to_rgb332(word[7:0]);
		right = to_rgb332(word[15:8]);
		case (mode)
			VIEW_LEFT:      return left;
			VIEW_RIGHT:     return right;
			VIEW_RED_RIGHT: return {right[7:5], left[4:0]};
			default:        return {left[7:5], right[4:0]};
		endcase
	endfunction

	function automatic mem_addr_t pixel_addr(input col_t col, input row_t row,
		input int unsigned stride);
		return mem_addr_t'(col) + mem_addr_t'(row) * mem_addr_t'(stride);
	endfunction

	assign rd_done = rd_strobe && mem_ack;

	// Raster advance, wraps at both frame edges
	always_comb begin
		x_next = x + 1'b1;
		y_next = y;
		if (x == LAST_COL) begin
			x_next = '0;
			y_next = (y == LAST_ROW) ? '0 : y + 1'b1;
		end
	end

	//================================================
	// Scan FSM
	//================================================

	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			state <= SCAN_READ;
			x <= '0;
			y <= '0;
			rd_strobe <= 1'b0;
			wr_strobe <= 1'b0;
		end else begin
			case (state)
				SCAN_READ: begin
					if (rd_done) begin
						rd_strobe <= 1'b0;
						wr_strobe <= 1'b1;
						state <= SCAN_WRITE;
					end else if (!rd_strobe && run) begin
						rd_strobe <= 1'b1;
					end
				end
				default: begin
					// Write goes out this cycle, next read follows at once
					wr_strobe <= 1'b0;
					x <= x_next;
					y <= y_next;
					rd_strobe <= run;
					state <= SCAN_READ;
				end
			endcase
		end
	end

	always_ff @(posedge CLOCK_50) begin
		if (rd_done) begin
			wr_data <= compose(mem_rdata, view_mode);
		end
	end

	// Both addresses follow the raster position, steady during a read
	assign mem_req = '{read: rd_strobe, addr: pixel_addr(x, y, FRAME_WIDTH)};
	assign fb_wr = '{write: wr_strobe, addr: pixel_addr(x, y, FB_STRIDE), data: wr_data};

endmodule

`default_nettype wire

// ==== hw/tracker_pkg.sv ====
//================================================
// Tracker shared types
//================================================

`default_nettype none

package tracker_pkg;

	// Calibration window is 2**7 = 128 samples
	localparam int CALIB_SAMPLES_LOG2 = 7;

	//================================================
	// Marker coordinates
	//================================================

	typedef logic [7:0] coord_t;

	// x in the top byte, z in the bottom byte
	typedef struct packed {
		coord_t x;
		coord_t y;
		coord_t z;
	} marker_coord_t;

	// Marker 0 sits in the low 24 bits
	typedef marker_coord_t [2:0] marker_set_t;

	// Index 3 behaves as marker 2
	typedef logic [1:0] marker_sel_t;

	// Height offset from baseline, range -255..255
	typedef logic signed [9:0] deviation_t;

	typedef enum logic [1:0] {
		FB_HOLD        = 2'd0,
		FB_MOVE_LOWER  = 2'd1,
		FB_MOVE_HIGHER = 2'd2,
		FB_CALIBRATING = 2'd3
	} feedback_code_t;

	//================================================
	// Stereo video path
	//================================================

	typedef enum logic [1:0] {
		VIEW_LEFT      = 2'd0,
		VIEW_RIGHT     = 2'd1,
		VIEW_RED_RIGHT = 2'd2,
		VIEW_RED_LEFT  = 2'd3
	} view_mode_t;

	// RGB332, red in the top bits
	typedef logic [7:0] pixel_t;

	// Low byte left image, high byte right image
	typedef logic [15:0] stereo_word_t;

	typedef logic [31:0] mem_addr_t;

	typedef struct packed {
		logic      read;
		mem_addr_t addr;
	} mem_req_t;

	typedef struct packed {
		logic      write;
		mem_addr_t addr;
		pixel_t    data;
	} fb_write_t;

endpackage

`default_nettype wire

// ==== hw/tracker_top.sv ====
//================================================
// Marker tracker core
//================================================

`default_nettype none

module tracker_top #(
	parameter int FRAME_WIDTH  = 320,
	parameter int FRAME_HEIGHT = 240,
	parameter int FB_STRIDE    = 1024
) (
	input  logic                        CLOCK_50,
	input  logic                        reset,
	input  logic                        run,
	input  tracker_pkg::marker_set_t    marker_coords,
	input  tracker_pkg::marker_sel_t    marker_sel,
	input  tracker_pkg::coord_t         threshold,
	input  tracker_pkg::view_mode_t     view_mode,
	output tracker_pkg::mem_req_t       mem_req,
	input  logic                        mem_ack,
	input  tracker_pkg::stereo_word_t   mem_rdata,
	output tracker_pkg::fb_write_t      fb_wr,
	output tracker_pkg::feedback_code_t feedback_code,
	output logic                        posture_wrong
);
	import tracker_pkg::*;

	marker_set_t calib_baseline;
	logic        calib_done;

	//================================================
	// Posture path
	//================================================

	baseline_calibrator u_calibrator (
		.CLOCK_50      (CLOCK_50),
		.reset         (reset),
		.run           (run),
		.marker_coords (marker_coords),
		.baseline      (calib_baseline),
		.done          (calib_done)
	);

	posture_feedback u_feedback (
		.CLOCK_50      (CLOCK_50),
		.reset         (reset),
		.run           (run),
		.calibrated    (calib_done),
		.marker_coords (marker_coords),
		.baseline      (calib_baseline),
		.marker_sel    (marker_sel),
		.threshold     (threshold),
		.feedback_code (feedback_code),
		.posture_wrong (posture_wrong)
	);

	//================================================
	// Video path
	//================================================

	stereo_compositor #(
		.FRAME_WIDTH  (FRAME_WIDTH),
		.FRAME_HEIGHT (FRAME_HEIGHT),
		.FB_STRIDE    (FB_STRIDE)
	) u_compositor (
		.CLOCK_50  (CLOCK_50),
		.reset     (reset),
		.run       (run),
		.view_mode (view_mode),
		.mem_req   (mem_req),
		.mem_ack   (mem_ack),
		.mem_rdata (mem_rdata),
		.fb_wr     (fb_wr)
	);

endmodule

`default_nettype wire

// ==== sim.f ====
hw/tracker_pkg.sv
hw/baseline_calibrator.sv
hw/posture_feedback.sv
hw/stereo_compositor.sv
hw/tracker_top.sv
tb/pixel_memory_model.sv
tb/tb_tracker_top.sv

// ==== tb/pixel_memory_model.sv ====
//================================================
// Stereo pixel memory responder
//================================================

`default_nettype none

module pixel_memory_model (
	input  logic                      CLOCK_50,
	input  logic                      reset,
	input  tracker_pkg::mem_req_t     mem_req,
	output logic                      mem_ack,
	output tracker_pkg::stereo_word_t mem_rdata
);
	timeunit 1ns;
	timeprecision 100ps;

	import tracker_pkg::*;

	int unsigned wait_cycles;
	logic        busy;

	initial begin
		mem_ack = 1'b0;
		mem_rdata = '0;
		busy = 1'b0;
		wait_cycles = 0;
	end

	// Responds just after the clock edge, like the rest of the stimulus
	always @(posedge CLOCK_50) begin
		#1;
		mem_ack = 1'b0;
		if (reset) begin
			busy = 1'b0;
		end else if (!busy && mem_req.read) begin
			busy = 1'b1;
			wait_cycles = $urandom_range(1, 4);
		end else if (busy) begin
			wait_cycles = wait_cycles - 1;
			if (wait_cycles == 0) begin
				// Word content depends on the full 16 low address bits
				mem_rdata = stereo_word_t'(mem_req.addr[15:0] * 16'd40503);
				mem_ack = 1'b1;
				busy = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb/tb_tracker_top.sv ====
//================================================
// Tracker core testbench
//================================================

`default_nettype none

module tb_tracker_top;
	timeunit 1ns;
	timeprecision 100ps;

	import tracker_pkg::*;

	localparam int FRAME_WIDTH  = 8;
	localparam int FRAME_HEIGHT = 4;
	localparam int FB_STRIDE    = 16;
	localparam int FRAME_PIXELS = FRAME_WIDTH * FRAME_HEIGHT;

	logic           CLOCK_50;
	logic           reset;
	logic           run;
	marker_set_t    marker_coords;
	marker_sel_t    marker_sel;
	coord_t         threshold;
	view_mode_t     view_mode;
	mem_req_t       mem_req;
	logic           mem_ack;
	stereo_word_t   mem_rdata;
	fb_write_t      fb_wr;
	feedback_code_t feedback_code;
	logic           posture_wrong;

	// Video monitor state
	int        pixel_idx;
	int        writes_seen;
	logic      write_due;
	pixel_t    due_pixel;
	logic      prev_read;
	logic      prev_run;
	mem_addr_t prev_addr;

	int     y_sum [3];
	coord_t base_y [3];

	tracker_top #(
		.FRAME_WIDTH  (FRAME_WIDTH),
		.FRAME_HEIGHT (FRAME_HEIGHT),
		.FB_STRIDE    (FB_STRIDE)
	) UUT (
		.CLOCK_50      (CLOCK_50),
		.reset         (reset),
		.run           (run),
		.marker_coords (marker_coords),
		.marker_sel    (marker_sel),
		.threshold     (threshold),
		.view_mode     (view_mode),
		.mem_req       (mem_req),
		.mem_ack       (mem_ack),
		.mem_rdata     (mem_rdata),
		.fb_wr         (fb_wr),
		.feedback_code (feedback_code),
		.posture_wrong (posture_wrong)
	);

	pixel_memory_model u_memory (
		.CLOCK_50  (CLOCK_50),
		.reset     (reset),
		.mem_req   (mem_req),
		.mem_ack   (mem_ack),
		.mem_rdata (mem_rdata)
	);

	always #5 CLOCK_50 = ~CLOCK_50;

	//================================================
	// Helpers
	//================================================

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic flag_mismatch(input string what);
		abort_run($sformatf("mismatch at %0d ns: %s", $time, what));
	endtask

	task automatic next_cycle();
		@(posedge CLOCK_50);
		#1;
	endtask

	// Stored order is red in 2..0, green in 5..3, blue in 7..6
	function automatic pixel_t unpack_pixel(input logic [7:0] raw);
		logic [2:0] red;
		logic [2:0] green;
		logic [1:0] blue;
		red = raw[2:0];
		green = raw[5:3];
		blue = raw[7:6];
		return {red, green, blue};
	endfunction

	function automatic pixel_t expected_pixel(input int idx, input view_mode_t mode);
		stereo_word_t word;
		pixel_t       left;
		pixel_t       right;
		word = stereo_word_t'(read_addr(idx) * 32'd40503);
		left = unpack_pixel(word[7:0]);
		right = unpack_pixel(word[15:8]);
		case (mode)
			VIEW_LEFT:      return left;
			VIEW_RIGHT:     return right;
			VIEW_RED_RIGHT: return {right[7:5], left[4:0]};
			default:        return {left[7:5], right[4:0]};
		endcase
	endfunction

	function automatic mem_addr_t read_addr(input int idx);
		return mem_addr_t'(idx % FRAME_WIDTH + (idx / FRAME_WIDTH) * FRAME_WIDTH);
	endfunction

	function automatic mem_addr_t write_addr(input int idx);
		return mem_addr_t'(idx % FRAME_WIDTH + (idx / FRAME_WIDTH) * FB_STRIDE);
	endfunction

	task automatic wait_for_writes(input int count);
		int target;
		int cycles;
		target = writes_seen + count;
		cycles = 0;
		while (writes_seen < target) begin
			next_cycle();
			cycles++;
			if (cycles > count * 20) begin
				abort_run("timed out waiting for frame buffer writes");
			end
		end
	endtask

	task automatic wait_for_hold();
		int cycles;
		cycles = 0;
		while (feedback_code != FB_HOLD) begin
			assert (feedback_code == FB_CALIBRATING)
				else flag_mismatch("unexpected code while calibration finishes");
			next_cycle();
			cycles++;
			if (cycles > 20) begin
				abort_run("timed out waiting for the end of calibration");
			end
		end
	endtask

	// Result must hold its old value one cycle on and change on the second
	task automatic classify_step(input int idx, input int y, input feedback_code_t code,
		input logic wrong);
		feedback_code_t old_code;
		logic           old_wrong;
		old_code = feedback_code;
		old_wrong = posture_wrong;
		marker_coords[idx].y = coord_t'(y);
		next_cycle();
		assert (feedback_code == old_code && posture_wrong == old_wrong)
			else flag_mismatch("posture result changed after only one cycle");
		next_cycle();
		assert (feedback_code == code)
			else flag_mismatch($sformatf("code %0d, expected %0d", feedback_code, code));
		assert (posture_wrong == wrong)
			else flag_mismatch($sformatf("posture_wrong %0b, expected %0b", posture_wrong, wrong));
	endtask

	//================================================
	// Video monitor
	//================================================

	always @(negedge CLOCK_50) begin
		if (reset) begin
			pixel_idx = 0;
			writes_seen = 0;
			write_due = 1'b0;
			prev_read = 1'b0;
			prev_run = 1'b0;
			prev_addr = '0;
		end else begin
			if (write_due) begin
				assert (fb_wr.write) else flag_mismatch("no frame write one cycle after mem_ack");
				assert (fb_wr.addr == write_addr(pixel_idx))
					else flag_mismatch($sformatf("write address %0d", fb_wr.addr));
				assert (fb_wr.data == due_pixel)
					else flag_mismatch($sformatf("pixel %h, expected %h", fb_wr.data, due_pixel));
				pixel_idx = (pixel_idx + 1) % FRAME_PIXELS;
				writes_seen++;
				write_due = 1'b0;
			end else begin
				assert (!fb_wr.write) else flag_mismatch("frame write without a mem_ack");
			end
			if (mem_req.read) begin
				assert (mem_req.addr == read_addr(pixel_idx))
					else flag_mismatch($sformatf("read address %0d", mem_req.addr));
				if (!prev_read) begin
					assert (prev_run) else flag_mismatch("read started while run was low");
				end else begin
					assert (mem_req.addr == prev_addr)
						else flag_mismatch("read address moved while waiting");
				end
				if (mem_ack) begin
					due_pixel = expected_pixel(pixel_idx, view_mode);
					write_due = 1'b1;
				end
			end
			prev_read = mem_req.read;
			prev_run = run;
			prev_addr = mem_req.addr;
		end
	end

	//================================================
	// Stimulus
	//================================================

	initial begin
		int          idx;
		int unsigned low_cycles;
		void'($urandom(19514));
		CLOCK_50 = 1'b0;
		reset = 1'b1;
		run = 1'b0;
		marker_coords = '0;
		marker_sel = '0;
		threshold = coord_t'(20);
		view_mode = VIEW_LEFT;
		repeat (3) next_cycle();
		reset = 1'b0;

		assert (feedback_code == FB_CALIBRATING) else flag_mismatch("code after reset");
		assert (!posture_wrong) else flag_mismatch("posture_wrong set after reset");
		assert (!mem_req.read && !fb_wr.write) else flag_mismatch("strobe high after reset");

		// 128 random samples, kept clear of the range edges
		for (int m = 0; m < 3; m++) y_sum[m] = 0;
		run = 1'b1;
		for (int i = 0; i < 128; i++) begin
			for (int m = 0; m < 3; m++) begin
				marker_coords[m].x = coord_t'($urandom_range(40, 215));
				marker_coords[m].y = coord_t'($urandom_range(40, 215));
				marker_coords[m].z = coord_t'($urandom_range(40, 215));
				y_sum[m] += marker_coords[m].y;
			end
			next_cycle();
			assert (feedback_code == FB_CALIBRATING)
				else flag_mismatch("code left calibrating before done");
		end
		for (int m = 0; m < 3; m++) begin
			base_y[m] = coord_t'(y_sum[m] / 128);
			marker_coords[m].y = base_y[m];
		end
		wait_for_hold();

		for (int sel = 0; sel < 4; sel++) begin
			idx = (sel == 3) ? 2 : sel;
			marker_sel = marker_sel_t'(sel);
			classify_step(idx, base_y[idx] + threshold + 1, FB_MOVE_LOWER, 1'b1);
			classify_step(idx, base_y[idx] - threshold - 1, FB_MOVE_HIGHER, 1'b1);
			classify_step(idx, base_y[idx] + threshold, FB_HOLD, 1'b0);
		end

		// Too low straight from rest leaves the flag clear
		classify_step(2, base_y[2] - threshold - 1, FB_MOVE_HIGHER, 1'b0);

		// Each mode covers more than a full frame
		for (int mode = 0; mode < 4; mode++) begin
			view_mode = view_mode_t'(mode);
			wait_for_writes(FRAME_PIXELS + 8);
		end

		// Stall the scan with run low
		for (int i = 0; i < 5; i++) begin
			run = 1'b0;
			low_cycles = $urandom_range(8, 12);
			repeat (low_cycles) next_cycle();
			assert (!mem_req.read && !fb_wr.write)
				else abort_run("memory traffic still active long after run went low");
			run = 1'b1;
			wait_for_writes(3);
		end

		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire
